//--- rtl/steer_consts.svh
`ifndef STEER_CONSTS_SVH
`define STEER_CONSTS_SVH

// datapath widths
`define STEER_TAPS        7
`define STEER_PIX_W       8
`define STEER_BASIS_W     28
`define STEER_SUM_W       31
`define STEER_OUT_W       16
`define STEER_BASIS_SHIFT 8

// h1 basis
`define COEF0_b 29
`define COEF1_b 101
`define COEF2_b 15
`define COEF3_b 235
`define COEF4_b 15
`define COEF5_b 101
`define COEF6_b 29

// f1 basis
`define COEF0_c 4
`define COEF1_c 42
`define COEF2_c 163
`define COEF3_c 255
`define COEF4_c 163
`define COEF5_c 42
`define COEF6_c 4

// f2 basis
`define COEF0_d 12
`define COEF1_d 77
`define COEF2_d 148
`define COEF3_d 0
`define COEF4_d 148
`define COEF5_d 77
`define COEF6_d 12

// h2 basis
`define COEF0_1 15
`define COEF1_1 25
`define COEF2_1 193
`define COEF3_1 0
`define COEF4_1 193
`define COEF5_1 25
`define COEF6_1 15

// f3 basis
`define COEF0_2 4
`define COEF1_2 42
`define COEF2_2 163
`define COEF3_2 255
`define COEF4_2 163
`define COEF5_2 42
`define COEF6_2 4

// h3 basis
`define COEF0_3 9
`define COEF1_3 56
`define COEF2_3 109
`define COEF3_3 0
`define COEF4_3 109
`define COEF5_3 56
`define COEF6_3 9

// h4 basis
`define COEF0_4 9
`define COEF1_4 56
`define COEF2_4 109
`define COEF3_4 0
`define COEF4_4 109
`define COEF5_4 56
`define COEF6_4 9

`endif

//--- rtl/steer_pkg.sv
`default_nettype none

`include "steer_consts.svh"

package steer_pkg;

	// seven basis responses, f1 in the top bits
	typedef struct packed
	{
		logic signed [`STEER_BASIS_W-1:0] f1;
		logic signed [`STEER_BASIS_W-1:0] f2;
		logic signed [`STEER_BASIS_W-1:0] f3;
		logic signed [`STEER_BASIS_W-1:0] h1;
		logic signed [`STEER_BASIS_W-1:0] h2;
		logic signed [`STEER_BASIS_W-1:0] h3;
		logic signed [`STEER_BASIS_W-1:0] h4;
	} basis_t;

	// three complex oriented outputs
	typedef struct packed
	{
		logic [`STEER_OUT_W-1:0] re_z;
		logic [`STEER_OUT_W-1:0] im_z;
		logic [`STEER_OUT_W-1:0] re_p;
		logic [`STEER_OUT_W-1:0] im_p;
		logic [`STEER_OUT_W-1:0] re_n;
		logic [`STEER_OUT_W-1:0] im_n;
	} steer_out_t;

endpackage

`default_nettype wire

//--- rtl/steer_cfg_pkg.sv
`default_nettype none

package steer_cfg_pkg;

	typedef enum logic
	{
		CFG_GAIN = 1'b0,
		CFG_MASK = 1'b1
	} cfg_addr_e;

	// orient_en bit 0 is z, bit 1 is p, bit 2 is n
	typedef struct packed
	{
		logic [1:0] gain;
		logic [2:0] orient_en;
	} steer_cfg_t;

endpackage

`default_nettype wire

//--- rtl/steer_cfg_regs.sv
`default_nettype none
`timescale 1ns/1ps

module steer_cfg_regs
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      we,
	input  steer_cfg_pkg::cfg_addr_e  addr,
	input  logic [2:0]                wdata,
	output steer_cfg_pkg::steer_cfg_t cfg
);

	import steer_cfg_pkg::*;

	logic [1:0] gain_q;
	logic [2:0] mask_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gain_q <= 2'd0;
			mask_q <= 3'b111;
		end
		else if (we)
		begin
			case (addr)
				CFG_GAIN:
					gain_q <= wdata[1:0];
				CFG_MASK:
					mask_q <= wdata;
			endcase
		end
	end

	assign cfg = '{gain: gain_q, orient_en: mask_q};

endmodule

`default_nettype wire

//--- rtl/basis_fir_bank.sv
`default_nettype none
`timescale 1ns/1ps

`include "steer_consts.svh"

module basis_fir_bank
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`STEER_PIX_W-1:0] pixel,
	input  logic                    pixel_valid,
	output steer_pkg::basis_t       basis,
	output logic                    basis_valid
);

	localparam int TAPS    = `STEER_TAPS;
	localparam int PIX_W   = `STEER_PIX_W;
	localparam int NPAIR   = (TAPS + 1) / 2;
	localparam int NFILT   = 7;
	localparam int PRE_W   = PIX_W + 1;
	localparam int PROD_W  = PRE_W + 8;
	localparam int RAW_W   = PROD_W + 2;
	localparam int BASIS_W = `STEER_BASIS_W;

	// rows in basis order f1 f2 f3 h1 h2 h3 h4, only the first half of each symmetric set
	localparam int COEF [NFILT][NPAIR] = '{
		'{`COEF0_c, `COEF1_c, `COEF2_c, `COEF3_c},
		'{`COEF0_d, `COEF1_d, `COEF2_d, `COEF3_d},
		'{`COEF0_2, `COEF1_2, `COEF2_2, `COEF3_2},
		'{`COEF0_b, `COEF1_b, `COEF2_b, `COEF3_b},
		'{`COEF0_1, `COEF1_1, `COEF2_1, `COEF3_1},
		'{`COEF0_3, `COEF1_3, `COEF2_3, `COEF3_3},
		'{`COEF0_4, `COEF1_4, `COEF2_4, `COEF3_4}
	};

	logic [PIX_W-1:0]  hist [TAPS-1];
	logic [PIX_W-1:0]  win [TAPS];
	logic [PRE_W-1:0]  pre [NPAIR];
	logic [PROD_W-1:0] prod [NFILT][NPAIR];
	logic [RAW_W-1:0]  raw_d [NFILT];
	logic [RAW_W-1:0]  raw [NFILT];
	logic [2:0]        fill;
	logic              prod_valid;

	function automatic logic signed [BASIS_W-1:0] to_basis(input logic [RAW_W-1:0] r);
		logic signed [BASIS_W-1:0] ext;
		ext = $signed({1'b0, r});
		return ext <<< `STEER_BASIS_SHIFT;
	endfunction

	// tap 0 is the incoming pixel, the rest come from history
	assign win[0] = pixel;
	for (genvar i = 1; i < TAPS; i++)
	begin : g_win
		assign win[i] = hist[i-1];
	end

	for (genvar k = 0; k < NPAIR; k++)
	begin : g_pre
		if (k == TAPS - 1 - k)
		begin : g_center
			assign pre[k] = PRE_W'(win[k]);
		end
		else
		begin : g_pair
			assign pre[k] = PRE_W'(win[k]) + PRE_W'(win[TAPS-1-k]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (pixel_valid)
		begin
			hist[0] <= pixel;
			for (int i = 1; i < TAPS - 1; i++)
				hist[i] <= hist[i-1];
			for (int f = 0; f < NFILT; f++)
				for (int k = 0; k < NPAIR; k++)
					prod[f][k] <= pre[k] * PROD_W'(COEF[f][k]);
		end
	end

	always_comb
	begin
		for (int f = 0; f < NFILT; f++)
		begin
			raw_d[f] = '0;
			for (int k = 0; k < NPAIR; k++)
				raw_d[f] = raw_d[f] + RAW_W'(prod[f][k]);
		end
	end

	always_ff @(posedge clk)
	begin
		raw <= raw_d;
	end

	// strobe only once the window is full
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fill        <= '0;
			prod_valid  <= 1'b0;
			basis_valid <= 1'b0;
		end
		else
		begin
			if (pixel_valid && fill != 3'(TAPS))
				fill <= fill + 3'd1;
			prod_valid  <= pixel_valid && (fill >= 3'(TAPS - 1));
			basis_valid <= prod_valid;
		end
	end

	assign basis = '{
		f1: to_basis(raw[0]),
		f2: to_basis(raw[1]),
		f3: to_basis(raw[2]),
		h1: to_basis(raw[3]),
		h2: to_basis(raw[4]),
		h3: to_basis(raw[5]),
		h4: to_basis(raw[6])
	};

endmodule

`default_nettype wire

//--- rtl/steer_fltr.sv
`default_nettype none
`timescale 1ns/1ps

`include "steer_consts.svh"

module steer_fltr
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      new_data,
	input  steer_pkg::basis_t         basis,
	input  steer_cfg_pkg::steer_cfg_t cfg,
	output steer_pkg::steer_out_t     result,
	output logic                      result_valid
);

	import steer_pkg::*;

	localparam int PART_W = `STEER_BASIS_W + 1;
	localparam int SUM_W  = `STEER_SUM_W;
	localparam int OUT_W  = `STEER_OUT_W;

	basis_t b_q;

	logic signed [PART_W-1:0] rz_t;
	logic signed [PART_W-1:0] iz_t;
	logic signed [PART_W-1:0] rp_t1;
	logic signed [PART_W-1:0] rp_t2;
	logic signed [PART_W-1:0] rp_t3;
	logic signed [PART_W-1:0] ip_t1;
	logic signed [PART_W-1:0] ip_t2;
	logic signed [PART_W-1:0] ip_t3;
	logic signed [PART_W-1:0] ip_t4;

	logic signed [SUM_W-1:0] rz_s;
	logic signed [SUM_W-1:0] iz_s;
	logic signed [SUM_W-1:0] rp_s;
	logic signed [SUM_W-1:0] ip_s;
	logic signed [SUM_W-1:0] rn_s;
	logic signed [SUM_W-1:0] in_s;

	logic [2:0] vpipe;

	// gain moves the 16-bit window down the sum
	function automatic logic [OUT_W-1:0] gain_slice(input logic [SUM_W-1:0] s, input logic [1:0] g);
		logic [SUM_W-1:0] sh;
		sh = s << g;
		return sh[SUM_W-1 -: OUT_W];
	endfunction

	always_ff @(posedge clk)
	begin
		if (new_data)
			b_q <= basis;
	end

	// partial terms, shifts stand in for the fractional weights
	always_ff @(posedge clk)
	begin
		rz_t  <= b_q.f1;
		iz_t  <= b_q.h1;
		rp_t1 <= b_q.f1 >>> 1;
		rp_t2 <= b_q.f3;
		rp_t3 <= b_q.f2 >>> 1;
		ip_t1 <= (b_q.h1 >>> 2) + (b_q.h1 >>> 3);
		ip_t2 <= b_q.h4 + (b_q.h4 >>> 4);
		ip_t3 <= b_q.h3 + (b_q.h3 >>> 4);
		ip_t4 <= (b_q.h2 >>> 2) + (b_q.h2 >>> 3);
	end

	always_ff @(posedge clk)
	begin
		rz_s <= rz_t;
		iz_s <= iz_t;
		rp_s <= rp_t1 - rp_t2 + rp_t3;
		ip_s <= ip_t1 - ip_t2 + ip_t3 - ip_t4;
		rn_s <= rp_t1 + rp_t2 + rp_t3;
		in_s <= ip_t1 + ip_t2 + ip_t3 + ip_t4;
	end

	always_ff @(posedge clk)
	begin
		result.re_z <= cfg.orient_en[0] ? gain_slice(rz_s, cfg.gain) : '0;
		result.im_z <= cfg.orient_en[0] ? gain_slice(iz_s, cfg.gain) : '0;
		result.re_p <= cfg.orient_en[1] ? gain_slice(rp_s, cfg.gain) : '0;
		result.im_p <= cfg.orient_en[1] ? gain_slice(ip_s, cfg.gain) : '0;
		result.re_n <= cfg.orient_en[2] ? gain_slice(rn_s, cfg.gain) : '0;
		result.im_n <= cfg.orient_en[2] ? gain_slice(in_s, cfg.gain) : '0;
	end

	// capture, partials, sums, then output
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vpipe        <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			vpipe        <= {vpipe[1:0], new_data};
			result_valid <= vpipe[2];
		end
	end

endmodule

`default_nettype wire

//--- rtl/steer_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "steer_consts.svh"

module steer_top
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`STEER_PIX_W-1:0]  pixel,
	input  logic                     pixel_valid,
	input  logic                     cfg_we,
	input  steer_cfg_pkg::cfg_addr_e cfg_addr,
	input  logic [2:0]               cfg_wdata,
	output steer_pkg::steer_out_t    result,
	output logic                     result_valid
);

	import steer_pkg::*;
	import steer_cfg_pkg::*;

	steer_cfg_t cfg;
	basis_t     basis;
	logic       basis_valid;

	steer_cfg_regs cfg0
	(
		.clk   (clk),
		.rst   (rst),
		.we    (cfg_we),
		.addr  (cfg_addr),
		.wdata (cfg_wdata),
		.cfg   (cfg)
	);

	basis_fir_bank fir0
	(
		.clk         (clk),
		.rst         (rst),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.basis       (basis),
		.basis_valid (basis_valid)
	);

	steer_fltr steer0
	(
		.clk          (clk),
		.rst          (rst),
		.new_data     (basis_valid),
		.basis        (basis),
		.cfg          (cfg),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

//--- dv/steer_top_sva.sv
`default_nettype none
`timescale 1ns/1ps

module steer_top_sva
(
	input logic                      clk,
	input logic                      rst,
	input logic                      pixel_valid,
	input logic                      result_valid,
	input steer_pkg::steer_out_t     result,
	input steer_cfg_pkg::steer_cfg_t cfg
);

	int fail_count = 0;

	// six cycles from accepted pixel to result
	a_latency: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(pixel_valid, 6))
	else
	begin
		$error("result_valid without a pixel six cycles earlier");
		fail_count++;
	end

	a_reset: assert property (@(posedge clk) rst |=> !result_valid)
	else
	begin
		$error("result_valid high right after reset");
		fail_count++;
	end

	a_mask_z: assert property (@(posedge clk) disable iff (rst)
		!cfg.orient_en[0] |=> (result.re_z == '0 && result.im_z == '0))
	else
	begin
		$error("disabled z pair is not zero");
		fail_count++;
	end

	a_mask_p: assert property (@(posedge clk) disable iff (rst)
		!cfg.orient_en[1] |=> (result.re_p == '0 && result.im_p == '0))
	else
	begin
		$error("disabled p pair is not zero");
		fail_count++;
	end

	a_mask_n: assert property (@(posedge clk) disable iff (rst)
		!cfg.orient_en[2] |=> (result.re_n == '0 && result.im_n == '0))
	else
	begin
		$error("disabled n pair is not zero");
		fail_count++;
	end

endmodule

bind steer_top steer_top_sva sva0
(
	.clk          (clk),
	.rst          (rst),
	.pixel_valid  (pixel_valid),
	.result_valid (result_valid),
	.result       (result),
	.cfg          (cfg)
);

`default_nettype wire

//--- dv/steer_top_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "steer_consts.svh"

module steer_top_tb;

	import steer_pkg::*;
	import steer_cfg_pkg::*;

	typedef enum logic [1:0]
	{
		K_CONST,
		K_RAMP,
		K_IMPULSE,
		K_RANDOM
	} kind_e;

	typedef struct packed
	{
		logic [63:0] name;
		logic [1:0]  gain;
		logic [2:0]  mask;
		logic [7:0]  len;
		kind_e       kind;
		logic [3:0]  gap;
	} test_t;

	localparam int NTESTS = 10;

	localparam test_t TESTS [NTESTS] = '{
		'{"warmup", 2'd0, 3'b111, 8'd7, K_RAMP, 4'd0},
		'{"impulse", 2'd0, 3'b111, 8'd20, K_IMPULSE, 4'd0},
		'{"constant", 2'd0, 3'b111, 8'd16, K_CONST, 4'd0},
		'{"ramp", 2'd0, 3'b111, 8'd24, K_RAMP, 4'd0},
		'{"gain_1", 2'd1, 3'b111, 8'd16, K_RANDOM, 4'd0},
		'{"gain_2", 2'd2, 3'b111, 8'd16, K_RANDOM, 4'd0},
		'{"gain_3", 2'd3, 3'b111, 8'd16, K_RANDOM, 4'd0},
		'{"mask_101", 2'd0, 3'b101, 8'd16, K_RANDOM, 4'd0},
		'{"mask_010", 2'd1, 3'b010, 8'd16, K_RANDOM, 4'd0},
		'{"sparse", 2'd0, 3'b111, 8'd14, K_RANDOM, 4'd3}
	};

	// rows f1 f2 f3 h1 h2 h3 h4, tap 0 is the newest pixel
	localparam int COEF_TAB [7][7] = '{
		'{`COEF0_c, `COEF1_c, `COEF2_c, `COEF3_c, `COEF4_c, `COEF5_c, `COEF6_c},
		'{`COEF0_d, `COEF1_d, `COEF2_d, `COEF3_d, `COEF4_d, `COEF5_d, `COEF6_d},
		'{`COEF0_2, `COEF1_2, `COEF2_2, `COEF3_2, `COEF4_2, `COEF5_2, `COEF6_2},
		'{`COEF0_b, `COEF1_b, `COEF2_b, `COEF3_b, `COEF4_b, `COEF5_b, `COEF6_b},
		'{`COEF0_1, `COEF1_1, `COEF2_1, `COEF3_1, `COEF4_1, `COEF5_1, `COEF6_1},
		'{`COEF0_3, `COEF1_3, `COEF2_3, `COEF3_3, `COEF4_3, `COEF5_3, `COEF6_3},
		'{`COEF0_4, `COEF1_4, `COEF2_4, `COEF3_4, `COEF4_4, `COEF5_4, `COEF6_4}
	};

	logic       clk;
	logic       rst;
	logic [7:0] pixel;
	logic       pixel_valid;
	logic       cfg_we;
	cfg_addr_e  cfg_addr;
	logic [2:0] cfg_wdata;
	steer_out_t result;
	logic       result_valid;

	int          cyc = 0;
	int          cyc_limit;
	logic [63:0] cur_name;
	logic [1:0]  cur_gain;
	logic [2:0]  cur_mask;
	logic [7:0]  mwin [7];
	int          mfill;
	steer_out_t  exp_res_q [$];
	int          exp_cyc_q [$];
	steer_out_t  got_exp;
	int          got_cyc;

	steer_top dut0
	(
		.clk          (clk),
		.rst          (rst),
		.pixel        (pixel),
		.pixel_valid  (pixel_valid),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.result       (result),
		.result_valid (result_valid)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string what, input logic [95:0] exp_v,
		input logic [95:0] act_v);
		if (exp_v !== act_v)
		begin
			$display("error: %s %s expected %h actual %h", cur_name, what, exp_v, act_v);
			$display("Done: errors found");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// bits [30-g : 15-g] of the 31-bit sum
	function automatic logic [15:0] slice_out(input longint s, input logic [1:0] g);
		logic [30:0] w;
		w = s[30:0];
		return 16'(w >> (15 - g));
	endfunction

	function automatic logic [7:0] make_pixel(input kind_e kind, input int i);
		case (kind)
			K_CONST:
				return 8'd255;
			K_RAMP:
				return 8'(i * 37 + 5);
			K_IMPULSE:
				return (i == 9) ? 8'd250 : 8'd0;
			default:
				return 8'($urandom());
		endcase
	endfunction

	// reference model, one call per accepted pixel
	task automatic model_pixel(input logic [7:0] p);
		longint     bas [7];
		longint     raw;
		longint     rt [3];
		longint     it [4];
		steer_out_t e;
		int         f;
		int         t;
		for (t = 6; t > 0; t--)
			mwin[t] = mwin[t-1];
		mwin[0] = p;
		if (mfill < 7)
			mfill++;
		if (mfill == 7)
		begin
			for (f = 0; f < 7; f++)
			begin
				raw = 0;
				for (t = 0; t < 7; t++)
					raw += longint'(mwin[t]) * COEF_TAB[f][t];
				bas[f] = raw <<< `STEER_BASIS_SHIFT;
			end
			rt[0] = bas[0] >>> 1;
			rt[1] = bas[2];
			rt[2] = bas[1] >>> 1;
			it[0] = (bas[3] >>> 2) + (bas[3] >>> 3);
			it[1] = bas[6] + (bas[6] >>> 4);
			it[2] = bas[5] + (bas[5] >>> 4);
			it[3] = (bas[4] >>> 2) + (bas[4] >>> 3);
			e.re_z = cur_mask[0] ? slice_out(bas[0], cur_gain) : 16'd0;
			e.im_z = cur_mask[0] ? slice_out(bas[3], cur_gain) : 16'd0;
			e.re_p = cur_mask[1] ? slice_out(rt[0] - rt[1] + rt[2], cur_gain) : 16'd0;
			e.im_p = cur_mask[1] ? slice_out(it[0] - it[1] + it[2] - it[3], cur_gain) : 16'd0;
			e.re_n = cur_mask[2] ? slice_out(rt[0] + rt[1] + rt[2], cur_gain) : 16'd0;
			e.im_n = cur_mask[2] ? slice_out(it[0] + it[1] + it[2] + it[3], cur_gain) : 16'd0;
			exp_res_q.push_back(e);
			exp_cyc_q.push_back(cyc + 6);
		end
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		pixel_valid = 1'b0;
		mfill = 0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic write_cfg(input cfg_addr_e addr, input logic [2:0] data);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic run_test(input test_t tst);
		int         i;
		logic [7:0] p;
		cur_name = tst.name;
		reset_dut();
		write_cfg(CFG_GAIN, {1'b0, tst.gain});
		write_cfg(CFG_MASK, tst.mask);
		cur_gain = tst.gain;
		cur_mask = tst.mask;
		for (i = 0; i < tst.len; i++)
		begin
			p = make_pixel(tst.kind, i);
			@(negedge clk);
			pixel = p;
			pixel_valid = 1'b1;
			model_pixel(p);
			repeat (tst.gap)
			begin
				@(negedge clk);
				pixel_valid = 1'b0;
			end
		end
		@(negedge clk);
		pixel_valid = 1'b0;
		while (exp_res_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	// outputs are registered, so mid-cycle sampling is stable
	always @(negedge clk)
	begin
		if (dut0.sva0.fail_count != 0)
		begin
			$display("error: %s a bound assertion failed", cur_name);
			$display("Done: errors found");
			$fatal(1, "assertion failure");
		end
		if (result_valid === 1'b1)
		begin
			if (exp_res_q.size() == 0)
			begin
				$display("error: %s result_valid with no pixel pending", cur_name);
				$display("Done: errors found");
				$fatal(1, "unexpected result");
			end
			got_exp = exp_res_q.pop_front();
			got_cyc = exp_cyc_q.pop_front();
			check_value("latency", 96'(got_cyc), 96'(cyc));
			check_value("result", got_exp, result);
		end
	end

	always @(posedge clk)
	begin
		cyc = cyc + 1;
		if (cyc > cyc_limit)
		begin
			$display("timeout: no result arrived within %0d cycles", cyc_limit);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		int i;
		void'($urandom(75));
		clk = 1'b0;
		rst = 1'b1;
		pixel = '0;
		pixel_valid = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = CFG_GAIN;
		cfg_wdata = '0;
		cur_name = "init";
		cur_gain = '0;
		cur_mask = 3'b111;
		mfill = 0;
		cyc_limit = 0;
		for (i = 0; i < NTESTS; i++)
			cyc_limit += TESTS[i].len * (TESTS[i].gap + 1) + 20;
		for (i = 0; i < NTESTS; i++)
			run_test(TESTS[i]);
		if (exp_res_q.size() == 0 && dut0.sva0.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- steer_top.f
+incdir+rtl
rtl/steer_pkg.sv
rtl/steer_cfg_pkg.sv
rtl/steer_cfg_regs.sv
rtl/basis_fir_bank.sv
rtl/steer_fltr.sv
rtl/steer_top.sv
dv/steer_top_sva.sv
dv/steer_top_tb.sv
